// File: tinyrv1_pkg.sv
`default_nettype none

package tinyrv1_pkg;

  // ==============================
  // Basic types
  // ==============================

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [6:0]  opcode_t;

  // RISC-V major opcodes for the supported subset
  localparam opcode_t OPC_OP_IMM = 7'b0010011;
  localparam opcode_t OPC_OP     = 7'b0110011;
  localparam opcode_t OPC_LOAD   = 7'b0000011;
  localparam opcode_t OPC_STORE  = 7'b0100011;
  localparam opcode_t OPC_JAL    = 7'b1101111;

  // funct7 that separates mul from add
  localparam logic [6:0] FUNCT7_MUL = 7'b0000001;

  localparam word_t RESET_PC = 32'h0000_0200;

  localparam int NUM_REGS  = 32;
  localparam int MUL_STEPS = 32;
  localparam int MUL_CNT_W = $clog2(MUL_STEPS);

  // ==============================
  // Controller states
  // ==============================

  typedef enum logic [1:0] {
    FETCH,
    EXEC,
    MUL_WAIT,
    WB
  } proc_state_e;

  // ==============================
  // Bundles between blocks
  // ==============================

  typedef struct packed {
    word_t op_a;
    word_t op_b;
    word_t pc;
    word_t inst;
  } int_op_t;

  typedef struct packed {
    word_t a;
    word_t b;
  } mul_req_t;

  typedef struct packed {
    logic  val;
    logic  wen;
    word_t addr;
    word_t wdata;
  } dmem_req_t;

  // One record per retired instruction
  typedef struct packed {
    word_t addr;
    word_t inst;
    word_t data;
  } trace_t;

endpackage

`default_nettype wire

// File: proc_int_unit.sv
`default_nettype none

module proc_int_unit import tinyrv1_pkg::*; (
  input  int_op_t op,
  output word_t   result,
  output word_t   target
);

  opcode_t opcode;
  word_t   imm_i;
  word_t   imm_s;
  word_t   imm_j;

  assign opcode = op.inst[6:0];

  // ==============================
  // Immediates
  // ==============================

  assign imm_i = {{20{op.inst[31]}}, op.inst[31:20]};
  assign imm_s = {{20{op.inst[31]}}, op.inst[31:25], op.inst[11:7]};

  // J-type bits are scrambled, bit 0 is always zero
  assign imm_j = {{12{op.inst[31]}}, op.inst[19:12], op.inst[20],
                  op.inst[30:21], 1'b0};

  // ==============================
  // Result select
  // ==============================

  always_comb begin
    case (opcode)
      OPC_OP_IMM: result = op.op_a + imm_i;
      OPC_LOAD:   result = op.op_a + imm_i;
      OPC_STORE:  result = op.op_a + imm_s;
      // Link value
      OPC_JAL:    result = op.pc + 32'd4;
      default:    result = op.op_a + op.op_b;
    endcase
  end

  // Jump target, only meaningful for jal
  assign target = op.pc + imm_j;

endmodule

`default_nettype wire

// File: proc_mul_unit.sv
`default_nettype none

module proc_mul_unit import tinyrv1_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     req,
  input  mul_req_t ops,
  output logic     ack,
  output word_t    result
);

  typedef enum logic [1:0] {
    MUL_IDLE,
    MUL_BUSY,
    MUL_DONE
  } mul_state_e;

  mul_state_e           state;
  logic [MUL_CNT_W-1:0] cnt;
  logic                 last_step;

  // Shift registers and running sum
  word_t mcand;
  word_t mplier;
  word_t acc;

  assign last_step = (cnt == MUL_CNT_W'(MUL_STEPS - 1));

  // ==============================
  // Control
  // ==============================

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= MUL_IDLE;
      cnt   <= '0;
    end else begin
      case (state)
        MUL_IDLE: begin
          if (req) begin
            state <= MUL_BUSY;
            cnt   <= '0;
          end
        end
        MUL_BUSY: begin
          cnt <= cnt + 1'b1;
          if (last_step) begin
            state <= MUL_DONE;
          end
        end
        // Wait for the requester to drop req
        MUL_DONE: begin
          if (!req) begin
            state <= MUL_IDLE;
          end
        end
        default: state <= MUL_IDLE;
      endcase
    end
  end

  // ==============================
  // Datapath
  // ==============================

  always_ff @(posedge clk) begin
    if (state == MUL_IDLE && req) begin
      mcand  <= ops.a;
      mplier <= ops.b;
      acc    <= '0;
    end else if (state == MUL_BUSY) begin
      if (mplier[0]) begin
        acc <= acc + mcand;
      end
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  // Low 32 bits of the product, held until req falls
  assign ack    = (state == MUL_DONE);
  assign result = acc;

endmodule

`default_nettype wire

// File: proc_ctrl.sv
`default_nettype none

module proc_ctrl import tinyrv1_pkg::*; (
  input  logic      clk,
  input  logic      rst,

  output word_t     imem_addr,
  input  word_t     imem_data,

  output dmem_req_t dmem_req,
  input  word_t     dmem_rdata,

  output int_op_t   int_op,
  input  word_t     int_result,
  input  word_t     int_target,

  output logic      mul_req,
  output mul_req_t  mul_ops,
  input  logic      mul_ack,
  input  word_t     mul_result,

  output logic      trace_val,
  output trace_t    trace
);

  proc_state_e state;
  proc_state_e state_next;

  word_t pc;
  word_t ir;
  word_t next_pc;
  word_t wb_data;

  word_t rf [NUM_REGS];

  // Decoded fields
  opcode_t    opcode;
  logic [6:0] funct7;
  reg_idx_t   rd;
  reg_idx_t   rs1;
  reg_idx_t   rs2;

  logic is_load;
  logic is_store;
  logic is_jal;
  logic is_mul;

  word_t rs1_val;
  word_t rs2_val;
  logic  rf_wen;

  // ==============================
  // Decode
  // ==============================

  assign opcode = ir[6:0];
  assign rd     = ir[11:7];
  assign rs1    = ir[19:15];
  assign rs2    = ir[24:20];
  assign funct7 = ir[31:25];

  assign is_load  = (opcode == OPC_LOAD);
  assign is_store = (opcode == OPC_STORE);
  assign is_jal   = (opcode == OPC_JAL);
  assign is_mul   = (opcode == OPC_OP) && (funct7 == FUNCT7_MUL);

  // x0 reads zero
  assign rs1_val = (rs1 == '0) ? '0 : rf[rs1];
  assign rs2_val = (rs2 == '0) ? '0 : rf[rs2];

  // ==============================
  // State machine
  // ==============================

  always_comb begin
    state_next = state;
    case (state)
      FETCH:    state_next = EXEC;
      EXEC:     state_next = is_mul ? MUL_WAIT : WB;
      MUL_WAIT: state_next = mul_ack ? WB : MUL_WAIT;
      WB:       state_next = FETCH;
      default:  state_next = FETCH;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= FETCH;
      pc    <= RESET_PC;
    end else begin
      state <= state_next;
      if (state == WB) begin
        pc <= next_pc;
      end
    end
  end

  // Instruction register loads during fetch
  always_ff @(posedge clk) begin
    if (state == FETCH) begin
      ir <= imem_data;
    end
  end

  // Writeback value and next pc, captured in EXEC or when the multiplier answers
  always_ff @(posedge clk) begin
    if (state == EXEC) begin
      next_pc <= is_jal ? int_target : pc + 32'd4;
      if (is_load) begin
        wb_data <= dmem_rdata;
      end else if (is_store) begin
        wb_data <= rs2_val;
      end else begin
        wb_data <= int_result;
      end
    end else if (state == MUL_WAIT && mul_ack) begin
      wb_data <= mul_result;
    end
  end

  // ==============================
  // Register file
  // ==============================

  assign rf_wen = (state == WB) && !is_store && (rd != '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        rf[i] <= '0;
      end
    end else if (rf_wen) begin
      rf[rd] <= wb_data;
    end
  end

  // ==============================
  // Outputs
  // ==============================

  assign imem_addr = pc;

  assign int_op.op_a = rs1_val;
  assign int_op.op_b = rs2_val;
  assign int_op.pc   = pc;
  assign int_op.inst = ir;

  // Memory access happens in EXEC only
  assign dmem_req.val   = (state == EXEC) && (is_load || is_store);
  assign dmem_req.wen   = (state == EXEC) && is_store;
  assign dmem_req.addr  = int_result;
  assign dmem_req.wdata = rs2_val;

  // Request held for the whole wait, drops in WB after ack
  assign mul_req   = (state == MUL_WAIT);
  assign mul_ops.a = rs1_val;
  assign mul_ops.b = rs2_val;

  assign trace_val  = (state == WB);
  assign trace.addr = pc;
  assign trace.inst = ir;
  assign trace.data = wb_data;

endmodule

`default_nettype wire

// File: proc_top.sv
`default_nettype none

module proc_top import tinyrv1_pkg::*; (
  input  logic      clk,
  input  logic      rst,

  output word_t     imem_addr,
  input  word_t     imem_data,

  output dmem_req_t dmem_req,
  input  word_t     dmem_rdata,

  output logic      trace_val,
  output trace_t    trace
);

  // Controller to integer unit
  int_op_t int_op;
  word_t   int_result;
  word_t   int_target;

  // Multiplier handshake
  logic     mul_req;
  mul_req_t mul_ops;
  logic     mul_ack;
  word_t    mul_result;

  proc_ctrl proc_ctrl_inst (
    .clk        (clk),
    .rst        (rst),
    .imem_addr  (imem_addr),
    .imem_data  (imem_data),
    .dmem_req   (dmem_req),
    .dmem_rdata (dmem_rdata),
    .int_op     (int_op),
    .int_result (int_result),
    .int_target (int_target),
    .mul_req    (mul_req),
    .mul_ops    (mul_ops),
    .mul_ack    (mul_ack),
    .mul_result (mul_result),
    .trace_val  (trace_val),
    .trace      (trace)
  );

  proc_int_unit proc_int_unit_inst (
    .op     (int_op),
    .result (int_result),
    .target (int_target)
  );

  proc_mul_unit proc_mul_unit_inst (
    .clk    (clk),
    .rst    (rst),
    .req    (mul_req),
    .ops    (mul_ops),
    .ack    (mul_ack),
    .result (mul_result)
  );

endmodule

`default_nettype wire

// File: proc_properties.sv
`default_nettype none

// Multiplier side of the req/ack handshake
module proc_properties import tinyrv1_pkg::*; (
  input logic     clk,
  input logic     rst,
  input logic     req,
  input mul_req_t ops,
  input logic     ack
);

  int fail_cnt = 0;

  // ack may outlive req by the one cycle it takes to see req fall
  ack_follows_req: assert property (@(posedge clk) disable iff (rst)
    ack |-> (req || $past(req)))
    else begin
      $error("ack was high without a preceding req");
      fail_cnt++;
    end

  ops_stable: assert property (@(posedge clk) disable iff (rst)
    (req && !ack && $past(req)) |-> $stable(ops))
    else begin
      $error("operands changed while req was waiting for ack");
      fail_cnt++;
    end

  ack_low_after_reset: assert property (@(posedge clk) $past(rst) |-> !ack)
    else begin
      $error("ack was high right after reset");
      fail_cnt++;
    end

endmodule

bind proc_mul_unit proc_properties proc_properties_inst (
  .clk (clk),
  .rst (rst),
  .req (req),
  .ops (ops),
  .ack (ack)
);

`default_nettype wire

// File: tb_checker.sv
`default_nettype none

module tb_checker import tinyrv1_pkg::*; (
  input logic   clk,
  input logic   rst,
  input logic   trace_val,
  input trace_t trace
);

  // Expected retirement records in program order
  trace_t exp_q [$];
  int     pending_cnt = 0;
  int     mismatch_cnt = 0;
  int     other_cnt = 0;

  task automatic push_expected(input trace_t rec);
    exp_q.push_back(rec);
    pending_cnt++;
  endtask

  task automatic report_failure(input string msg);
    $display("Error: %s", msg);
    other_cnt++;
  endtask

  task automatic compare_field(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
      mismatch_cnt++;
    end
  endtask

  // ==============================
  // Trace monitor
  // ==============================

  // Trace is stable at the falling edge
  always @(negedge clk) begin
    trace_t exp_rec;
    if (rst) begin
      if (trace_val !== 1'b0) begin
        report_failure("trace_val was high during reset");
      end
    end else if (trace_val === 1'b1) begin
      if (exp_q.size() == 0) begin
        report_failure($sformatf("unexpected retirement at address 0x%h", trace.addr));
      end else begin
        exp_rec = exp_q.pop_front();
        pending_cnt--;
        compare_field("trace.addr", trace.addr, exp_rec.addr);
        compare_field("trace.inst", trace.inst, exp_rec.inst);
        compare_field("trace.data", trace.data, exp_rec.data);
      end
    end
  end

  task automatic print_summary(input int assert_cnt);
    $display("tb_checker: %0d errors (%0d mismatch, %0d other, %0d assert), %0d left",
             mismatch_cnt + other_cnt + assert_cnt, mismatch_cnt, other_cnt, assert_cnt,
             pending_cnt);
  endtask

endmodule

`default_nettype wire

// File: tb_top.sv
`default_nettype none

module tb_top import tinyrv1_pkg::*; ();

  // Instruction kinds used in the stimulus table
  typedef enum logic [2:0] {I_ADDI, I_ADD, I_MUL, I_LW, I_SW, I_JAL} kind_e;

  typedef struct packed {
    word_t    addr;
    kind_e    kind;
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    word_t    imm;
    word_t    data;
  } row_t;

  logic      clk;
  logic      rst;
  word_t     imem_addr;
  word_t     imem_data;
  dmem_req_t dmem_req;
  word_t     dmem_rdata;
  logic      trace_val;
  trace_t    trace;

  word_t imem [1024];
  word_t dmem [1024];
  row_t  prog [$];
  word_t products [4];
  word_t seed = 32'h3f79;
  int    assert_cnt;

  proc_top proc_top_inst (
    .clk        (clk),
    .rst        (rst),
    .imem_addr  (imem_addr),
    .imem_data  (imem_data),
    .dmem_req   (dmem_req),
    .dmem_rdata (dmem_rdata),
    .trace_val  (trace_val),
    .trace      (trace)
  );

  tb_checker tb_checker_inst (
    .clk       (clk),
    .rst       (rst),
    .trace_val (trace_val),
    .trace     (trace)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ==============================
  // Memory models
  // ==============================

  assign imem_data  = imem[imem_addr[11:2]];
  assign dmem_rdata = dmem[dmem_req.addr[11:2]];

  always @(posedge clk) begin
    if (dmem_req.val && dmem_req.wen) begin
      dmem[dmem_req.addr[11:2]] <= dmem_req.wdata;
    end
  end

  function automatic word_t lcg_next(input word_t s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic word_t encode(input row_t r);
    case (r.kind)
      I_ADDI:  return {r.imm[11:0], r.rs1, 3'b000, r.rd, OPC_OP_IMM};
      I_ADD:   return {7'b0000000, r.rs2, r.rs1, 3'b000, r.rd, OPC_OP};
      I_MUL:   return {FUNCT7_MUL, r.rs2, r.rs1, 3'b000, r.rd, OPC_OP};
      I_LW:    return {r.imm[11:0], r.rs1, 3'b010, r.rd, OPC_LOAD};
      I_SW:    return {r.imm[11:5], r.rs2, r.rs1, 3'b010, r.imm[4:0], OPC_STORE};
      default: return {r.imm[20], r.imm[10:1], r.imm[11], r.imm[19:12], r.rd, OPC_JAL};
    endcase
  endfunction

  task automatic add_row(input word_t addr, input kind_e kind, input int rd, input int rs1,
                         input int rs2, input int imm, input word_t data);
    prog.push_back({addr, kind, 5'(rd), 5'(rs1), 5'(rs2), 32'(imm), data});
  endtask

  // Encode every row into imem and queue its expected record
  task automatic load_program();
    trace_t rec;
    foreach (prog[i]) begin
      imem[prog[i].addr[11:2]] = encode(prog[i]);
      rec.addr = prog[i].addr;
      rec.inst = encode(prog[i]);
      rec.data = prog[i].data;
      tb_checker_inst.push_expected(rec);
    end
    prog.delete();
  endtask

  // Each pair runs lw, lw, mul and sw with LCG operands
  task automatic build_mul_program();
    word_t a;
    word_t b;
    word_t pc;
    pc = RESET_PC;
    for (int k = 0; k < 4; k++) begin
      seed = lcg_next(seed);
      a = seed;
      seed = lcg_next(seed);
      b = seed;
      products[k] = a * b;
      dmem[256 + 2 * k] <= a;
      dmem[257 + 2 * k] <= b;
      add_row(pc,      I_LW,  1, 0, 0, 'h400 + 8 * k, a);
      add_row(pc + 4,  I_LW,  2, 0, 0, 'h404 + 8 * k, b);
      add_row(pc + 8,  I_MUL, 3, 1, 2, 0, products[k]);
      add_row(pc + 12, I_SW,  0, 0, 3, 'h600 + 4 * k, products[k]);
      pc = pc + 16;
    end
    add_row(pc, I_JAL, 0, 0, 0, 0, pc + 4);
    load_program();
  endtask

  task automatic wait_drained(input int limit, input string what);
    int cycles;
    cycles = 0;
    while (tb_checker_inst.pending_cnt != 0 && cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    if (tb_checker_inst.pending_cnt != 0) begin
      tb_checker_inst.report_failure($sformatf("%s did not retire within %0d cycles",
                                               what, limit));
    end
  endtask

  // ==============================
  // Main sequence
  // ==============================

  initial begin
    rst <= 1'b1;
    for (int i = 0; i < 1024; i++) begin
      dmem[i] <= 32'hdead_0000 | (i << 2);
    end
    dmem[64] <= 32'h0001_0001;
    dmem[65] <= 32'h8000_0003;

    //      addr        kind    rd  rs1 rs2  imm     trace data
    add_row(32'h200, I_ADDI,  1,  0,  0,  5,      32'h0000_0005);
    add_row(32'h204, I_ADDI,  2,  0,  0, -3,      32'hffff_fffd);
    add_row(32'h208, I_ADD,   3,  1,  2,  0,      32'h0000_0002);
    add_row(32'h20c, I_ADDI,  0,  1,  0,  7,      32'h0000_000c);
    add_row(32'h210, I_ADD,   4,  0,  1,  0,      32'h0000_0005);
    add_row(32'h214, I_MUL,   5,  1,  2,  0,      32'hffff_fff1);
    add_row(32'h218, I_MUL,   6,  1,  0,  0,      32'h0000_0000);
    add_row(32'h21c, I_LW,    7,  0,  0, 'h100,   32'h0001_0001);
    add_row(32'h220, I_LW,    8,  0,  0, 'h104,   32'h8000_0003);
    add_row(32'h224, I_MUL,   9,  7,  7,  0,      32'h0002_0001);
    add_row(32'h228, I_MUL,  10,  2,  2,  0,      32'h0000_0009);
    add_row(32'h22c, I_MUL,  11,  8,  2,  0,      32'h7fff_fff7);
    add_row(32'h230, I_SW,    0,  0,  3, 'h108,   32'h0000_0002);
    add_row(32'h234, I_SW,    0,  1, 11, 'h107,   32'h7fff_fff7);
    add_row(32'h238, I_ADDI, 14,  0,  0, 'h110,   32'h0000_0110);
    add_row(32'h23c, I_LW,   12,  0,  0, 'h108,   32'h0000_0002);
    add_row(32'h240, I_LW,   13, 14,  0, -4,      32'h7fff_fff7);
    add_row(32'h244, I_JAL,  15,  0,  0, 12,      32'h0000_0248);
    add_row(32'h250, I_JAL,  17,  0,  0, -8,      32'h0000_0254);
    add_row(32'h248, I_ADDI, 16, 15,  0,  1,      32'h0000_0249);
    // Self loop that the next reset cuts off
    add_row(32'h24c, I_JAL,   0,  0,  0,  0,      32'h0000_0250);
    load_program();

    repeat (3) @(posedge clk);
    rst <= 1'b0;
    wait_drained(2000, "directed program");
    tb_checker_inst.compare_field("dmem[0x108]", dmem[66], 32'h0000_0002);
    tb_checker_inst.compare_field("dmem[0x10c]", dmem[67], 32'h7fff_fff7);

    rst <= 1'b1;
    @(posedge clk);
    build_mul_program();
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    wait_drained(2000, "random mul program");
    for (int k = 0; k < 4; k++) begin
      tb_checker_inst.compare_field($sformatf("dmem[0x%h]", 'h600 + 4 * k),
                                    dmem[384 + k], products[k]);
    end

    assert_cnt = proc_top_inst.proc_mul_unit_inst.proc_properties_inst.fail_cnt;
    tb_checker_inst.print_summary(assert_cnt);
    if (tb_checker_inst.mismatch_cnt + tb_checker_inst.other_cnt + assert_cnt == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
tinyrv1_pkg.sv
proc_int_unit.sv
proc_mul_unit.sv
proc_ctrl.sv
proc_top.sv
proc_properties.sv
tb_checker.sv
tb_top.sv

// File: Bender.yml
package:
  name: tinyrv1_proc

sources:
  - tinyrv1_pkg.sv
  - proc_int_unit.sv
  - proc_mul_unit.sv
  - proc_ctrl.sv
  - proc_top.sv
  - target: test
    files:
      - proc_properties.sv
      - tb_checker.sv
      - tb_top.sv
